//--- design/bpu.sv
// -------------------------------------------------------------------
// Branch predictor: gshare direction plus BTB target
// -------------------------------------------------------------------
module bpu (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  logic [fetch_pkg::XLEN-1:0]   pc_i,
  input  fetch_pkg::resolution_t       res_i,
  output fetch_pkg::prediction_t       pred_o
);
  import fetch_pkg::*;

  logic             gs_taken;
  logic             btb_hit;
  logic [XLEN-1:0]  btb_target;

  // Every valid resolution trains direction
  gshare u_gshare (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .pc_i         (pc_i),
    .res_valid_i  (res_i.valid),
    .res_pc_i     (res_i.pc),
    .res_taken_i  (res_i.taken),
    .taken_o      (gs_taken)
  );

  // Only taken branches get a target entry
  btb u_btb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pc_i         (pc_i),
    .upd_valid_i  (res_i.valid & res_i.taken),
    .upd_pc_i     (res_i.pc),
    .upd_target_i (res_i.target),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  // Taken needs a known target and a taken counter
  always_comb begin
    pred_o.pc     = pc_i;
    pred_o.taken  = btb_hit & gs_taken;
    pred_o.target = pred_o.taken ? btb_target : pc_i + XLEN'(4);
  end

  // Execute flags a mispredict only on a real resolution
  res_valid_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    res_i.mispredict |-> res_i.valid
  );

endmodule

//--- design/btb.sv
// -------------------------------------------------------------------
// Branch target buffer: direct mapped, tagged, valid per entry
// -------------------------------------------------------------------
module btb (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0]   pc_i,
  input  logic                         upd_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]   upd_pc_i,
  input  logic [fetch_pkg::XLEN-1:0]   upd_target_i,
  output logic                         hit_o,
  output logic [fetch_pkg::XLEN-1:0]   target_o
);
  import fetch_pkg::*;

  // Tag and target stored side by side
  typedef struct packed {
    logic [BTB_TAG_BITS-1:0]  tag;
    logic [XLEN-1:0]          target;
  } btb_entry_t;

  logic [2**BTB_BITS-1:0]   valid_q;
  btb_entry_t               entry_q [2**BTB_BITS];
  logic [BTB_BITS-1:0]      rd_idx;
  logic [BTB_BITS-1:0]      wr_idx;
  logic [BTB_TAG_BITS-1:0]  rd_tag;
  logic [BTB_TAG_BITS-1:0]  wr_tag;

  // Index above the instruction offset, tag right above the index
  assign rd_idx = pc_i[BTB_BITS+1:2];
  assign rd_tag = pc_i[BTB_TAG_BITS+BTB_BITS+1:BTB_BITS+2];
  assign wr_idx = upd_pc_i[BTB_BITS+1:2];
  assign wr_tag = upd_pc_i[BTB_TAG_BITS+BTB_BITS+1:BTB_BITS+2];

  // Lookup
  assign hit_o    = valid_q[rd_idx] && (entry_q[rd_idx].tag == rd_tag);
  assign target_o = entry_q[rd_idx].target;

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Entry storage, last writer owns the slot
  always_ff @(posedge clk_i) begin
    if (upd_valid_i) begin
      entry_q[wr_idx] <= '{tag: wr_tag, target: upd_target_i};
    end
  end

endmodule

//--- design/fetch_pkg.sv
// -------------------------------------------------------------------
// Fetch stage package: widths, predictor table sizes, shared structs
// -------------------------------------------------------------------
package fetch_pkg;

  // -------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------
  // Address and PC width
  localparam int XLEN = 64;
  // Instruction width, no compressed support
  localparam int ILEN = 32;
  // Instructions per cache line, 128-bit lines
  localparam int LINE_WORDS = 4;
  // Byte offset bits inside one line
  localparam int LINE_OFF_BITS = 4;

  // -------------------------------------------------------------------
  // Predictor sizes
  // -------------------------------------------------------------------
  // Global history length, also sets the 2^HLEN pattern table
  // Gshare index is pc[HLEN+1:2] xor history, for lookup and update alike
  localparam int HLEN = 4;
  // BTB index width, 16 direct-mapped entries
  localparam int BTB_BITS = 4;
  // Tag bits kept per BTB entry, taken just above the index
  localparam int BTB_TAG_BITS = 8;

  // -------------------------------------------------------------------
  // Shared structs
  // -------------------------------------------------------------------
  // One cache line as returned by the cache
  typedef struct packed {
    // Low LINE_OFF_BITS always zero
    logic [XLEN-1:0]                  line_addr;
    logic [LINE_WORDS-1:0][ILEN-1:0]  line;
  } icache_out_t;

  // Prediction that travels with a fetched instruction
  typedef struct packed {
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  target;
    logic             taken;
  } prediction_t;

  // Branch resolution broadcast by execute
  typedef struct packed {
    logic             valid;
    logic             mispredict;
    logic             taken;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  target;
  } resolution_t;

endpackage

//--- design/fetch_stage.sv
// -------------------------------------------------------------------
// Fetch stage top: cache interface, fetch unit and branch predictor
// -------------------------------------------------------------------
module fetch_stage (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,

  // PC generation
  input  logic [fetch_pkg::XLEN-1:0]   pc_i,
  output logic                         fetch_ready_o,

  // Instruction cache
  output logic [fetch_pkg::XLEN-1:0]   addr_o,
  output logic                         addr_valid_o,
  input  logic                         addr_ready_i,
  input  fetch_pkg::icache_out_t       data_i,
  input  logic                         data_valid_i,
  output logic                         data_ready_o,

  // Decode
  input  logic                         issue_ready_i,
  output logic                         issue_valid_o,
  output logic [fetch_pkg::ILEN-1:0]   instruction_o,
  output fetch_pkg::prediction_t       pred_o,

  // Branch resolution from execute
  input  fetch_pkg::resolution_t       res_i
);
  import fetch_pkg::*;

  logic         read_req;
  logic         read_done;
  logic         bpu_flush;
  icache_out_t  cache_out;
  prediction_t  pred;

  // -------------------------------------------------------------------
  // Cache interface
  // -------------------------------------------------------------------
  icache_ifc u_icache_ifc (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .pc_i         (pc_i),
    .read_req_i   (read_req),
    .cache_out_o  (cache_out),
    .read_done_o  (read_done),
    .addr_o       (addr_o),
    .addr_valid_o (addr_valid_o),
    .addr_ready_i (addr_ready_i),
    .data_i       (data_i),
    .data_valid_i (data_valid_i),
    .data_ready_o (data_ready_o)
  );

  // -------------------------------------------------------------------
  // Fetch unit
  // -------------------------------------------------------------------
  ifu u_ifu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pc_i          (pc_i),
    .fetch_ready_o (fetch_ready_o),
    .cache_out_i   (cache_out),
    .read_done_i   (read_done),
    .read_req_o    (read_req),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .instruction_o (instruction_o),
    .pred_i        (pred),
    .pred_o        (pred_o)
  );

  // -------------------------------------------------------------------
  // Branch predictor
  // -------------------------------------------------------------------
  // Mispredict flush keeps history, the resolution corrects it
  assign bpu_flush = flush_i & ~res_i.mispredict;

  bpu u_bpu (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (bpu_flush),
    .pc_i    (pc_i),
    .res_i   (res_i),
    .pred_o  (pred)
  );

endmodule

//--- design/gshare.sv
// -------------------------------------------------------------------
// Gshare: global history and table of 2-bit saturating counters
// -------------------------------------------------------------------
module gshare (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  logic [fetch_pkg::XLEN-1:0]   pc_i,
  input  logic                         res_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]   res_pc_i,
  input  logic                         res_taken_i,
  output logic                         taken_o
);
  import fetch_pkg::*;

  logic [HLEN-1:0]  ghr_q;
  logic [1:0]       pht_q [2**HLEN];
  logic [HLEN-1:0]  rd_idx;
  logic [HLEN-1:0]  wr_idx;

  // Hashed indices, both against the current history
  assign rd_idx  = pc_i[HLEN+1:2] ^ ghr_q;
  assign wr_idx  = res_pc_i[HLEN+1:2] ^ ghr_q;
  // Upper counter bit is the direction
  assign taken_o = pht_q[rd_idx][1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ghr_q <= '0;
      // Weakly not taken
      for (int i = 0; i < 2**HLEN; i++) begin
        pht_q[i] <= 2'b01;
      end
    end else begin
      if (res_valid_i) begin
        // Saturating counter step
        if (res_taken_i && pht_q[wr_idx] != 2'b11) begin
          pht_q[wr_idx] <= pht_q[wr_idx] + 2'd1;
        end else if (!res_taken_i && pht_q[wr_idx] != 2'b00) begin
          pht_q[wr_idx] <= pht_q[wr_idx] - 2'd1;
        end
        // Newest outcome enters at bit 0
        ghr_q <= {ghr_q[HLEN-2:0], res_taken_i};
      end
      // Flush touches history only
      if (flush_i) begin
        ghr_q <= '0;
      end
    end
  end

endmodule

//--- design/icache_ifc.sv
// -------------------------------------------------------------------
// I-cache interface: line read handshakes, capture and flush squash
// -------------------------------------------------------------------
module icache_ifc (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,

  // Fetch unit side
  input  logic [fetch_pkg::XLEN-1:0]   pc_i,
  input  logic                         read_req_i,
  output fetch_pkg::icache_out_t       cache_out_o,
  output logic                         read_done_o,

  // Cache side
  output logic [fetch_pkg::XLEN-1:0]   addr_o,
  output logic                         addr_valid_o,
  input  logic                         addr_ready_i,
  input  fetch_pkg::icache_out_t       data_i,
  input  logic                         data_valid_i,
  output logic                         data_ready_o
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_t;

  state_t           state_q;
  logic [XLEN-1:0]  addr_q;
  logic [XLEN-1:0]  pend_addr_q;
  logic [XLEN-1:0]  req_addr;
  logic             squash_q;
  logic             pend_q;
  logic             read_done_q;
  logic             beat;
  icache_out_t      line_q;

  // Line aligned request address
  assign req_addr = {pc_i[XLEN-1:LINE_OFF_BITS], {LINE_OFF_BITS{1'b0}}};
  assign beat     = data_valid_i & data_ready_o;

  assign addr_o       = addr_q;
  assign addr_valid_o = (state_q == ADDR);
  assign data_ready_o = (state_q == DATA);
  assign cache_out_o  = line_q;
  assign read_done_o  = read_done_q;

  // -------------------------------------------------------------------
  // Control FSM
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      squash_q    <= 1'b0;
      pend_q      <= 1'b0;
      read_done_q <= 1'b0;
    end else begin
      // Done pulse one cycle after a live beat
      read_done_q <= beat & ~squash_q & ~flush_i;
      if (state_q == IDLE) begin
        if (read_req_i) begin
          state_q <= ADDR;
          addr_q  <= req_addr;
        end
      end else begin
        // New request behind a squashed read waits its turn
        if (read_req_i) begin
          pend_q      <= 1'b1;
          pend_addr_q <= req_addr;
        end
        // Read in flight is now stale, pending one too
        if (flush_i) begin
          squash_q <= 1'b1;
          pend_q   <= 1'b0;
        end
        if (state_q == ADDR && addr_ready_i) begin
          state_q <= DATA;
        end
        if (beat) begin
          squash_q <= 1'b0;
          pend_q   <= 1'b0;
          if ((pend_q | read_req_i) & ~flush_i) begin
            state_q <= ADDR;
            addr_q  <= read_req_i ? req_addr : pend_addr_q;
          end else begin
            state_q <= IDLE;
          end
        end
      end
    end
  end

  // Line capture, payload only
  always_ff @(posedge clk_i) begin
    if (beat) begin
      line_q <= data_i;
    end
  end

  // Address channel holds until the cache takes it
  addr_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    addr_valid_o && !addr_ready_i |=> addr_valid_o && $stable(addr_o)
  );

endmodule

//--- design/ifu.sv
// -------------------------------------------------------------------
// Fetch unit: line buffer, word select, decode-side output register
// -------------------------------------------------------------------
module ifu (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,

  // PC generation side
  input  logic [fetch_pkg::XLEN-1:0]   pc_i,
  output logic                         fetch_ready_o,

  // Cache interface side
  input  fetch_pkg::icache_out_t       cache_out_i,
  input  logic                         read_done_i,
  output logic                         read_req_o,

  // Decode side
  input  logic                         issue_ready_i,
  output logic                         issue_valid_o,
  output logic [fetch_pkg::ILEN-1:0]   instruction_o,
  input  fetch_pkg::prediction_t       pred_i,
  output fetch_pkg::prediction_t       pred_o
);
  import fetch_pkg::*;

  // Line buffer
  logic                       lb_valid_q;
  icache_out_t                lb_q;
  // Miss in progress, word index and prediction of the waiting PC
  logic                       busy_q;
  logic [LINE_OFF_BITS-3:0]   word_q;
  prediction_t                pred_q;
  // Output register
  logic                       out_valid_q;
  logic [ILEN-1:0]            instr_q;
  prediction_t                pred_out_q;

  logic                       out_free;
  logic                       lb_hit;
  logic                       refill;

  // Output empty, or drained this cycle
  assign out_free      = ~out_valid_q | issue_ready_i;
  assign fetch_ready_o = ~busy_q & out_free & ~flush_i;

  // Same line as the buffered one
  assign lb_hit = lb_valid_q &&
                  (lb_q.line_addr[XLEN-1:LINE_OFF_BITS] == pc_i[XLEN-1:LINE_OFF_BITS]);

  // Miss on acceptance goes straight to the cache interface
  assign read_req_o = fetch_ready_o & ~lb_hit;
  assign refill     = busy_q & read_done_i;

  assign issue_valid_o = out_valid_q;
  assign instruction_o = instr_q;
  assign pred_o        = pred_out_q;

  // -------------------------------------------------------------------
  // Control
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lb_valid_q  <= 1'b0;
      busy_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (flush_i) begin
      // Buffer may hold a line from the wrong path
      lb_valid_q  <= 1'b0;
      busy_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (read_req_o) begin
        busy_q <= 1'b1;
      end
      if (refill) begin
        busy_q     <= 1'b0;
        lb_valid_q <= 1'b1;
      end
      if ((fetch_ready_o && lb_hit) || refill) begin
        out_valid_q <= 1'b1;
      end else if (issue_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // -------------------------------------------------------------------
  // Payload
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    // Prediction latched together with the PC
    if (fetch_ready_o) begin
      word_q <= pc_i[LINE_OFF_BITS-1:2];
      pred_q <= pred_i;
    end
    if (refill) begin
      lb_q       <= cache_out_i;
      instr_q    <= cache_out_i.line[word_q];
      pred_out_q <= pred_q;
    end else if (fetch_ready_o && lb_hit) begin
      // Hit, issue next cycle
      instr_q    <= lb_q.line[pc_i[LINE_OFF_BITS-1:2]];
      pred_out_q <= pred_i;
    end
  end

  // Decode output holds under back-pressure
  issue_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_o && !issue_ready_i && !flush_i |=>
      issue_valid_o && $stable(instruction_o) && $stable(pred_o)
  );

endmodule

//--- src.f
design/fetch_pkg.sv
design/icache_ifc.sv
design/gshare.sv
design/btb.sv
design/bpu.sv
design/ifu.sv
design/fetch_stage.sv
verification/icache_model.sv
verification/tb_fetch_stage.sv

//--- verification/icache_model.sv
// -------------------------------------------------------------------
// Behavioral I-cache: word k of line A is A xor k, random delays
// -------------------------------------------------------------------
module icache_model (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0]   addr_i,
  input  logic                         addr_valid_i,
  output logic                         addr_ready_o,
  output fetch_pkg::icache_out_t       data_o,
  output logic                         data_valid_o,
  input  logic                         data_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  logic [XLEN-1:0]  line_addr;
  int unsigned      delay;

  initial begin
    addr_ready_o = 1'b0;
    data_valid_o = 1'b0;
    data_o       = '0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && addr_valid_i) begin
        // Address channel, 1 to 6 cycles
        delay = $urandom_range(1, 6);
        repeat (delay - 1) @(negedge clk_i);
        addr_ready_o = 1'b1;
        line_addr    = addr_i;
        @(negedge clk_i);
        addr_ready_o = 1'b0;
        // Data channel, 1 to 6 cycles, interface already waits for it
        delay = $urandom_range(1, 6);
        repeat (delay - 1) @(negedge clk_i);
        data_o.line_addr = line_addr;
        for (int k = 0; k < LINE_WORDS; k++) begin
          data_o.line[k] = line_addr[ILEN-1:0] ^ ILEN'(k);
        end
        data_valid_o = 1'b1;
        @(negedge clk_i);
        data_valid_o = 1'b0;
      end
    end
  end

endmodule

//--- verification/tb_fetch_stage.sv
// -------------------------------------------------------------------
// Fetch stage testbench with scoreboard and shadow predictor
// -------------------------------------------------------------------
module tb_fetch_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  logic clk_i, rst_n_i, flush_i, fetch_ready_o;
  logic addr_valid_o, addr_ready_i, data_valid_i, data_ready_o;
  logic issue_ready_i, issue_valid_o;
  logic [XLEN-1:0] pc_i, addr_o;
  logic [ILEN-1:0] instruction_o;
  icache_out_t     data_i;
  prediction_t     pred_o;
  resolution_t     res_i;

  // Scoreboard and bookkeeping
  logic [XLEN-1:0] exp_pc_q [$];
  prediction_t     exp_pred_q [$];
  // PC whose issue a test waits for
  logic [XLEN-1:0] watch_pc;
  prediction_t     last_pred;
  logic            watch_seen;
  logic            bp_en;
  int              errors, hs_cnt, err_base, pass_cnt, fail_cnt, n;
  // Shadow predictor
  logic [HLEN-1:0]          ghr_sh;
  logic [1:0]               pht_sh [2**HLEN];
  logic [2**BTB_BITS-1:0]   bv_sh;
  logic [BTB_TAG_BITS-1:0]  btag_sh [2**BTB_BITS];
  logic [XLEN-1:0]          btgt_sh [2**BTB_BITS];

  fetch_stage fetch_stage_i (.*);

  icache_model u_cache (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .addr_i (addr_o), .addr_valid_i (addr_valid_o),
    .addr_ready_o (addr_ready_i), .data_o (data_i), .data_valid_o (data_valid_i),
    .data_ready_i (data_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Taken only on a tagged BTB hit with a taken counter
  function automatic prediction_t predict(logic [XLEN-1:0] pc);
    prediction_t p;
    logic [BTB_BITS-1:0] bi;
    bi       = pc[BTB_BITS+1:2];
    p.pc     = pc;
    p.taken  = bv_sh[bi] && btag_sh[bi] == pc[BTB_TAG_BITS+BTB_BITS+1:BTB_BITS+2] &&
               pht_sh[pc[HLEN+1:2] ^ ghr_sh][1];
    p.target = p.taken ? btgt_sh[bi] : pc + 64'd4;
    return p;
  endfunction

  // -------------------------------------------------------------------
  // Shadow predictor update
  // -------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [HLEN-1:0] wi;
    logic [BTB_BITS-1:0] bi;
    wi = res_i.pc[HLEN+1:2] ^ ghr_sh;
    bi = res_i.pc[BTB_BITS+1:2];
    if (!rst_n_i) begin
      ghr_sh <= '0;
      bv_sh  <= '0;
      for (int i = 0; i < 2**HLEN; i++) pht_sh[i] <= 2'b01;
    end else begin
      if (res_i.valid) begin
        if (res_i.taken && pht_sh[wi] != 2'b11) pht_sh[wi] <= pht_sh[wi] + 2'd1;
        if (!res_i.taken && pht_sh[wi] != 2'b00) pht_sh[wi] <= pht_sh[wi] - 2'd1;
        ghr_sh <= {ghr_sh[HLEN-2:0], res_i.taken};
        // Only taken branches own a BTB slot
        if (res_i.taken) begin
          bv_sh[bi]   <= 1'b1;
          btag_sh[bi] <= res_i.pc[BTB_TAG_BITS+BTB_BITS+1:BTB_BITS+2];
          btgt_sh[bi] <= res_i.target;
        end
      end
      // History survives a mispredict flush
      if (flush_i && !res_i.mispredict) ghr_sh <= '0;
    end
  end

  // -------------------------------------------------------------------
  // Scoreboard monitor
  // -------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [XLEN-1:0] epc;
    logic [ILEN-1:0] exp_instr;
    prediction_t     epred;
    // Address handshakes seen on the cache side
    if (addr_valid_o && addr_ready_i) hs_cnt++;
    if (!rst_n_i || flush_i) begin
      exp_pc_q.delete();
      exp_pred_q.delete();
    end else begin
      if (issue_valid_o && issue_ready_i) begin
        assert (exp_pc_q.size() > 0) else begin
          errors++;
          $display("instruction issued with no accepted PC left");
        end
        if (exp_pc_q.size() > 0) begin
          epc       = exp_pc_q.pop_front();
          epred     = exp_pred_q.pop_front();
          // Word k of line A is A xor k
          exp_instr = epc[ILEN-1:0] & ~ILEN'(15);
          exp_instr = exp_instr ^ ILEN'(epc[LINE_OFF_BITS-1:2]);
          assert (instruction_o == exp_instr) else begin
            errors++;
            $display("ERR instruction_o got %h exp %h", instruction_o, exp_instr);
          end
          assert (pred_o == epred) else begin
            errors++;
            $display("ERR pred_o got %h exp %h", pred_o, epred);
          end
          last_pred = pred_o;
          if (epc == watch_pc) watch_seen = 1'b1;
        end
      end
      // Every accepted PC must issue once, in order
      if (fetch_ready_o) begin
        exp_pc_q.push_back(pc_i);
        exp_pred_q.push_back(predict(pc_i));
      end
    end
  end

  // Random back-pressure stretches
  always @(negedge clk_i) begin
    if (bp_en) issue_ready_i = ($urandom_range(0, 2) != 0);
  end

  // -------------------------------------------------------------------
  // Assertions
  // -------------------------------------------------------------------
  reset_a: assert property (@(posedge clk_i) !rst_n_i |=>
    !issue_valid_o && !addr_valid_o && !data_ready_o && fetch_ready_o)
    else begin
      errors++;
      $display("outputs wrong after reset");
    end
  hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_o && !issue_ready_i && !flush_i |=>
      issue_valid_o && $stable(instruction_o) && $stable(pred_o))
    else begin
      errors++;
      $display("decode output changed under back-pressure");
    end
  stall_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_o && !issue_ready_i |-> !fetch_ready_o)
    else begin
      errors++;
      $display("PC accepted while output stalled");
    end
  ghr_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_stage_i.u_bpu.u_gshare.ghr_q == ghr_sh)
    else begin
      errors++;
      $display("ERR ghr_q got %h exp %h", fetch_stage_i.u_bpu.u_gshare.ghr_q, ghr_sh);
    end

  // -------------------------------------------------------------------
  // Tasks
  // -------------------------------------------------------------------
  task automatic abort(string what);
    $display("timeout waiting for %s", what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic report(string name);
    if (errors == err_base) pass_cnt++;
    else fail_cnt++;
    $display("test %s: %s", name, errors == err_base ? "pass" : "fail");
    err_base = errors;
  endtask

  // Present a PC and wait until it issues
  task automatic run_pc(logic [XLEN-1:0] pc);
    @(negedge clk_i);
    pc_i       = pc;
    watch_pc   = pc;
    watch_seen = 1'b0;
    n = 0;
    while (!watch_seen && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 200) abort("issue of a PC");
  endtask

  // One-cycle resolution broadcast with optional flush
  task automatic resolve(logic [XLEN-1:0] pc, logic tk, logic mis, logic fl);
    @(negedge clk_i);
    res_i   = '{valid: 1'b1, mispredict: mis, taken: tk, pc: pc, target: 64'h2000_0000};
    flush_i = fl;
    @(negedge clk_i);
    res_i   = '0;
    flush_i = 1'b0;
  endtask

  task automatic pulse_flush();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  // -------------------------------------------------------------------
  // Stimulus
  // -------------------------------------------------------------------
  initial begin
    logic [XLEN-1:0] pc;
    logic [HLEN-1:0] idx;
    int hs0;
    void'($urandom(3810));
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    pc_i          = 64'h100;
    issue_ready_i = 1'b1;
    res_i         = '0;
    bp_en         = 1'b0;
    watch_pc      = '1;
    watch_seen    = 1'b0;
    errors        = 0;
    hs_cnt        = 0;
    err_base      = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // Reset state and untrained prediction
    assert (fetch_stage_i.pred.taken == 1'b0 && fetch_stage_i.pred.target == pc_i + 4)
      else begin
        errors++;
        $display("ERR pred got %h exp not taken with target %h",
                 fetch_stage_i.pred, pc_i + 64'd4);
      end
    report("reset");

    // Random lines under random cache delay
    for (int i = 0; i < 12; i++) run_pc({$urandom, $urandom} & ~64'h3);
    report("line_data");

    // Second PC in a buffered line
    pc = {$urandom, $urandom} & ~64'hf;
    run_pc(pc);
    @(negedge clk_i);
    hs0 = hs_cnt;
    pc_i = pc + 8;
    n = 0;
    while (!fetch_ready_o && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 200) abort("fetch ready on hit");
    @(negedge clk_i);
    // Word 2 of the line one cycle after acceptance
    assert (issue_valid_o && instruction_o == (pc[ILEN-1:0] ^ 32'd2))
      else begin
        errors++;
        $display("ERR instruction_o got %h exp %h on hit", instruction_o,
                 pc[ILEN-1:0] ^ 32'd2);
      end
    // A miss would have raised the address channel by now
    assert (!addr_valid_o && hs_cnt == hs0)
      else begin
        errors++;
        $display("hit started a cache read");
      end
    report("line_hit");

    // Back-pressure with mixed lines
    bp_en = 1'b1;
    for (int i = 0; i < 10; i++) run_pc(i % 3 == 0 ? pc + 4 : {$urandom, $urandom} & ~64'h3);
    bp_en = 1'b0;
    issue_ready_i = 1'b1;
    report("backpressure");

    // Flush while the data beat is awaited
    pc = {$urandom, $urandom} & ~64'h3;
    @(negedge clk_i);
    pc_i = pc;
    n = 0;
    while (!data_ready_o && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 200) abort("data channel");
    hs0 = hs_cnt;
    // Flush no later than the beat itself
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    n = 0;
    while (!issue_valid_o && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 200) abort("issue after flush");
    // Issue must come from a fresh read
    assert (hs_cnt > hs0) else begin
      errors++;
      $display("flushed line was issued");
    end
    report("flush_miss");

    // Predictor training then history on flush
    pc  = 64'h1000_0040;
    idx = pc[HLEN+1:2];
    pulse_flush();
    resolve(pc, 1'b1, 1'b0, 1'b0);
    assert (fetch_stage_i.u_bpu.u_gshare.pht_q[idx] == 2'b10)
      else begin
        errors++;
        $display("ERR pht_q got %h exp 2", fetch_stage_i.u_bpu.u_gshare.pht_q[idx]);
      end
    pulse_flush();
    run_pc(pc);
    assert (last_pred.taken && last_pred.target == 64'h2000_0000)
      else begin
        errors++;
        $display("ERR pred_o got %h exp taken with target %h", last_pred, 64'h2000_0000);
      end
    pulse_flush();
    resolve(pc, 1'b1, 1'b0, 1'b0);
    assert (fetch_stage_i.u_bpu.u_gshare.pht_q[idx] == 2'b11)
      else begin
        errors++;
        $display("ERR pht_q got %h exp 3", fetch_stage_i.u_bpu.u_gshare.pht_q[idx]);
      end
    // Mispredict flush keeps the shifted history
    resolve(pc + 64'h20, 1'b0, 1'b1, 1'b1);
    assert (fetch_stage_i.u_bpu.u_gshare.ghr_q == 4'b0010)
      else begin
        errors++;
        $display("ERR ghr_q got %h exp 2", fetch_stage_i.u_bpu.u_gshare.ghr_q);
      end
    pulse_flush();
    run_pc(pc + 4);
    report("predictor");

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
